// ==== design/router_pkg.sv ====
/*
 * Router package. Direction codes and port sizing shared by the
 * output arbitration stage of the five-port mesh router.
 */
package router_pkg;

        // ====================
        // Port count and order
        // ====================

        // Bit i of every request, pointer and grant vector is the input
        // port whose direction code is i, in the order N, S, W, E, L.
        localparam int NUM_PORTS = 5;

        typedef logic [NUM_PORTS-1:0] port_vec_t; // One bit per router port.

        // ====================
        // Next-hop codes
        // ====================

        // Codes 5 and 6 have no name and count as no request.
        typedef enum logic [2:0] {
                DIR_N    = 3'd0,
                DIR_S    = 3'd1,
                DIR_W    = 3'd2,
                DIR_E    = 3'd3,
                DIR_L    = 3'd4,
                DIR_NONE = 3'd7 // Input has no head flit waiting.
        } dir_e;

endpackage

// ==== design/route_req_if.sv ====
/*
 * Route request bundle. Carries the next-hop code of the head flit
 * at each of the five input ports to every output processor.
 */
`timescale 1ns/100ps

interface route_req_if import router_pkg::*; ();

        dir_e nexthop_n; // Next hop of the North input.
        dir_e nexthop_s; // Next hop of the South input.
        dir_e nexthop_w; // Next hop of the West input.
        dir_e nexthop_e; // Next hop of the East input.
        dir_e nexthop_l; // Next hop of the Local input.

        modport alloc (
                output nexthop_n, nexthop_s, nexthop_w, nexthop_e, nexthop_l
        );

        // Every processor only looks at the codes.
        modport proc (
                input nexthop_n, nexthop_s, nexthop_w, nexthop_e, nexthop_l
        );

endinterface

// ==== design/rr_comparator.sv ====
/*
 * Request comparator. Turns the five next-hop codes into the request
 * vector of one output direction and masks the U-turn request.
 */
`timescale 1ns/100ps

module rr_comparator import router_pkg::*; #(
        parameter dir_e OWN_DIR = DIR_N
) (
        route_req_if.proc req,
        output port_vec_t request_o
);

        dir_e hop [NUM_PORTS]; // Next hop per input, indexed by input direction.

        // ====================
        // Gather codes
        // ====================

        assign hop[DIR_N] = req.nexthop_n;
        assign hop[DIR_S] = req.nexthop_s;
        assign hop[DIR_W] = req.nexthop_w;
        assign hop[DIR_E] = req.nexthop_e;
        assign hop[DIR_L] = req.nexthop_l;

        // ====================
        // Decode
        // ====================

        // An input wants this output when its next hop names it. A flit
        // never leaves through the port it came in on, so the input that
        // shares this direction is dropped. Codes 5 to 7 never match.
        always_comb begin
                for (int i = 0; i < NUM_PORTS; i++) begin
                        request_o[i] = (hop[i] == OWN_DIR) && (i != int'(OWN_DIR));
                end
        end

endmodule

// ==== design/rr_priority_ring.sv ====
/*
 * Priority ring. Holds the one-hot round-robin pointer of one output
 * and moves it one place past the granted input on each advance.
 */
`timescale 1ns/100ps

module rr_priority_ring import router_pkg::*; (
        input  logic      clk,
        input  logic      rst_n_i,
        input  logic      advance_i,
        input  port_vec_t grant_i,
        output port_vec_t pointer_o
);

        port_vec_t pointer_q; // Current highest-priority input.
        port_vec_t pointer_d;

        // ====================
        // Next pointer
        // ====================

        // The input after the winner gets first pick next time. The grant
        // is rotated left by one, so L wraps back around to N.
        always_comb begin
                pointer_d = pointer_q;
                if (advance_i) begin
                        pointer_d = {grant_i[NUM_PORTS-2:0], grant_i[NUM_PORTS-1]};
                end
        end

        // ====================
        // Pointer register
        // ====================

        always_ff @(posedge clk) begin
                if (!rst_n_i) begin
                        pointer_q <= port_vec_t'(1 << DIR_N); // North starts with priority.
                end else begin
                        pointer_q <= pointer_d;
                end
        end

        assign pointer_o = pointer_q;

endmodule

// ==== design/grant_encoder.sv ====
/*
 * Round-robin grant encoder. Searches the request vector cyclically
 * from the pointer bit and grants the first requester it finds.
 */
`timescale 1ns/100ps

module grant_encoder import router_pkg::*; (
        input  port_vec_t request_i,
        input  port_vec_t pointer_i,
        output port_vec_t grant_o,
        output logic      grant_valid_o
);

        port_vec_t at_or_above; // Thermometer mask from the pointer bit upward.
        port_vec_t req_upper;   // Requests that do not need the wrap.

        // Keeps only the lowest set bit of a vector.
        function automatic port_vec_t lowest_set(input port_vec_t vec);
                return vec & (~vec + port_vec_t'(1));
        endfunction

        // ====================
        // Split the search
        // ====================

        // Subtracting one from a one-hot pointer sets every bit below it,
        // so the inverse marks the pointer bit and all bits above it.
        assign at_or_above = ~(pointer_i - port_vec_t'(1));
        assign req_upper   = request_i & at_or_above;

        // ====================
        // Pick the winner
        // ====================

        // Requests at or above the pointer come first. If there are none
        // the search wraps, and the lowest request overall wins.
        always_comb begin
                if (req_upper != '0) begin
                        grant_o = lowest_set(req_upper);
                end else begin
                        grant_o = lowest_set(request_i);
                end
        end

        assign grant_valid_o = |request_i; // Level to the crossbar switch.

endmodule

// ==== design/rr_processor.sv ====
/*
 * Round-robin processor. Arbitrates one output port of the router
 * and presents a one-hot grant with its valid level to the crossbar.
 */
`timescale 1ns/100ps

module rr_processor import router_pkg::*; #(
        parameter dir_e OWN_DIR = DIR_N
) (
        input  logic      clk,
        input  logic      rst_n_i,
        route_req_if.proc req,
        input  logic      change_order_i,
        output port_vec_t grant_o,
        output logic      grant_valid_o
);

        port_vec_t request; // Inputs that want this output.
        port_vec_t pointer; // Where the cyclic search begins.
        logic      advance; // Rotate priority at the end of this cycle.

        // ====================
        // Request decode
        // ====================

        rr_comparator #(
                .OWN_DIR (OWN_DIR)
        ) comparator_inst (
                .req       (req),
                .request_o (request)
        );

        // ====================
        // Priority state
        // ====================

        // The crossbar pulses change order when the tail has passed. With
        // no grant there is no winner, so an idle pulse is ignored.
        assign advance = change_order_i & grant_valid_o;

        rr_priority_ring ring_inst (
                .clk       (clk),
                .rst_n_i   (rst_n_i),
                .advance_i (advance),
                .grant_i   (grant_o),
                .pointer_o (pointer)
        );

        // ====================
        // Grant
        // ====================

        grant_encoder encoder_inst (
                .request_i     (request),
                .pointer_i     (pointer),
                .grant_o       (grant_o),
                .grant_valid_o (grant_valid_o)
        );

endmodule

// ==== design/switch_allocator.sv ====
/*
 * Switch allocator. Output arbitration stage of the five-port mesh
 * router with one round-robin processor per output direction.
 */
`timescale 1ns/100ps

module switch_allocator import router_pkg::*; (
        input  logic      clk,
        input  logic      rst_n_i,

        // Next hop of the head flit at each input port.
        input  dir_e      nexthop_n_i,
        input  dir_e      nexthop_s_i,
        input  dir_e      nexthop_w_i,
        input  dir_e      nexthop_e_i,
        input  dir_e      nexthop_l_i,

        input  port_vec_t change_order_i, // Tail passed, one bit per output.

        // One-hot winner per output, bit i is input direction i.
        output port_vec_t grant_n_o,
        output port_vec_t grant_s_o,
        output port_vec_t grant_w_o,
        output port_vec_t grant_e_o,
        output port_vec_t grant_l_o,
        output port_vec_t grant_valid_o
);

        port_vec_t grant [NUM_PORTS]; // Grant vector per output direction.

        // ====================
        // Request bundle
        // ====================

        route_req_if req_bus ();

        assign req_bus.nexthop_n = nexthop_n_i;
        assign req_bus.nexthop_s = nexthop_s_i;
        assign req_bus.nexthop_w = nexthop_w_i;
        assign req_bus.nexthop_e = nexthop_e_i;
        assign req_bus.nexthop_l = nexthop_l_i;

        // ====================
        // Output processors
        // ====================

        // Each output arbitrates on its own. The outputs never fight
        // over an input, because an input names a single next hop.
        for (genvar g = 0; g < NUM_PORTS; g++) begin : gen_proc
                rr_processor #(
                        .OWN_DIR (dir_e'(g))
                ) processor_inst (
                        .clk            (clk),
                        .rst_n_i        (rst_n_i),
                        .req            (req_bus.proc),
                        .change_order_i (change_order_i[g]),
                        .grant_o        (grant[g]),
                        .grant_valid_o  (grant_valid_o[g])
                );
        end

        assign grant_n_o = grant[DIR_N];
        assign grant_s_o = grant[DIR_S];
        assign grant_w_o = grant[DIR_W];
        assign grant_e_o = grant[DIR_E];
        assign grant_l_o = grant[DIR_L];

endmodule

// ==== tests/tb_switch_allocator.sv ====
/*
 * Testbench for the switch allocator. Random next-hop codes and change
 * order pulses, a pointer model per output and assertion checks.
 */
`timescale 1ns/100ps

module tb_switch_allocator import router_pkg::*; ();

        localparam int RANDOM_CYCLES  = 2000;
        localparam int TIMEOUT_CYCLES = 2500; // Reset, directed phases and 2000 random cycles.

        logic      clk = 1'b0;
        logic      rst_n;
        dir_e      hop [NUM_PORTS];          // Next hop per input, indexed by input direction.
        port_vec_t change_order;
        port_vec_t grant [NUM_PORTS];        // Grant per output direction.
        port_vec_t grant_valid;
        port_vec_t request [NUM_PORTS];      // Expected requesters per output.
        port_vec_t expect_grant [NUM_PORTS];
        port_vec_t model_ptr [NUM_PORTS];
        port_vec_t taken_by [NUM_PORTS];     // Outputs that grant each input.
        logic      any_request;
        int        cycle_count = 0;

        always #50 clk = ~clk;

        switch_allocator switch_allocator_inst (
                .clk            (clk),
                .rst_n_i        (rst_n),
                .nexthop_n_i    (hop[DIR_N]),
                .nexthop_s_i    (hop[DIR_S]),
                .nexthop_w_i    (hop[DIR_W]),
                .nexthop_e_i    (hop[DIR_E]),
                .nexthop_l_i    (hop[DIR_L]),
                .change_order_i (change_order),
                .grant_n_o      (grant[DIR_N]),
                .grant_s_o      (grant[DIR_S]),
                .grant_w_o      (grant[DIR_W]),
                .grant_e_o      (grant[DIR_E]),
                .grant_l_o      (grant[DIR_L]),
                .grant_valid_o  (grant_valid)
        );

        task automatic stop_with_error(input string line);
                $display("%s", line);
                $display("Errors found");
                $fatal(1);
        endtask

        // Walks the ring from the pointer and returns the first requester, one-hot.
        function automatic port_vec_t search_from_pointer(input port_vec_t req,
                                                          input port_vec_t ptr);
                int        start;
                int        idx;
                port_vec_t result;
                start  = 0;
                result = '0;
                for (int i = 0; i < NUM_PORTS; i++) begin
                        if (ptr[i]) begin
                                start = i;
                        end
                end
                // Going backwards lets the nearest requester overwrite the others.
                for (int k = NUM_PORTS - 1; k >= 0; k--) begin
                        idx = (start + k) % NUM_PORTS;
                        if (req[idx]) begin
                                result = port_vec_t'(1) << idx;
                        end
                end
                return result;
        endfunction

        function automatic dir_e random_hop();
                int roll;
                roll = int'($urandom % 100);
                if (roll < 30) begin
                        return DIR_NONE;
                end else if (roll < 35) begin
                        return dir_e'(3'(5 + $urandom % 2)); // Unnamed codes mean no request.
                end
                return dir_e'(3'($urandom % NUM_PORTS));
        endfunction

        // ====================
        // Reference model
        // ====================

        always_comb begin
                any_request = 1'b0;
                for (int o = 0; o < NUM_PORTS; o++) begin
                        for (int i = 0; i < NUM_PORTS; i++) begin
                                request[o][i] = (int'(hop[i]) == o) && (i != o);
                                taken_by[i][o] = grant[o][i];
                        end
                        expect_grant[o] = search_from_pointer(request[o], model_ptr[o]);
                        any_request = any_request | (|request[o]);
                end
        end

        // The pointer moves one place past the winner when the tail has passed.
        always @(posedge clk) begin
                for (int o = 0; o < NUM_PORTS; o++) begin
                        if (!rst_n) begin
                                model_ptr[o] <= port_vec_t'(1);
                        end else if (change_order[o] && (expect_grant[o] != '0)) begin
                                model_ptr[o] <= {expect_grant[o][NUM_PORTS-2:0],
                                                 expect_grant[o][NUM_PORTS-1]};
                        end
                end
        end

        // ====================
        // Assertions
        // ====================

        for (genvar g = 0; g < NUM_PORTS; g++) begin : gen_check
                grant_order: assert property (@(posedge clk) disable iff (!rst_n)
                        grant[g] == expect_grant[g])
                else stop_with_error($sformatf(
                        "CHECK FAILED at %0t: output %0d granted %b, expected %b",
                        $time, g, grant[g], expect_grant[g]));
                grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
                        $onehot0(grant[g]) && ((grant[g] != '0) == grant_valid[g]))
                else stop_with_error($sformatf(
                        "CHECK FAILED at %0t: output %0d grant %b, valid %b",
                        $time, g, grant[g], grant_valid[g]));
                grant_legal: assert property (@(posedge clk) disable iff (!rst_n)
                        (grant[g] & ~request[g]) == '0)
                else stop_with_error($sformatf(
                        "CHECK FAILED at %0t: output %0d granted non-requester %b",
                        $time, g, grant[g]));
                no_uturn: assert property (@(posedge clk) disable iff (!rst_n)
                        !grant[g][g] && (grant_valid[g] == |request[g]))
                else stop_with_error($sformatf(
                        "CHECK FAILED at %0t: output %0d U-turn or bad valid",
                        $time, g));
                input_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
                        $onehot0(taken_by[g]))
                else stop_with_error($sformatf(
                        "CHECK FAILED at %0t: input %0d granted by outputs %b",
                        $time, g, taken_by[g]));
        end

        idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
                any_request || (grant_valid == '0))
        else stop_with_error($sformatf("CHECK FAILED at %0t: grant valid %b with no requests",
                $time, grant_valid));

        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= TIMEOUT_CYCLES) begin
                        stop_with_error("Timeout, the run did not finish in the cycle limit");
                end
        end

        // ====================
        // Stimulus
        // ====================

        initial begin
                void'($urandom(61853));
                rst_n        <= 1'b0;
                change_order <= '0;
                for (int i = 0; i < NUM_PORTS; i++) begin
                        hop[i] <= DIR_NONE;
                end
                repeat (4) @(posedge clk);
                rst_n <= 1'b1;
                repeat (6) begin // Idle phase with codes 5 to 7 only.
                        @(posedge clk);
                        for (int i = 0; i < NUM_PORTS; i++) begin
                                hop[i] <= dir_e'(3'(5 + $urandom % 3));
                        end
                        change_order <= port_vec_t'($urandom);
                end
                repeat (6) begin // Every input names its own direction.
                        @(posedge clk);
                        for (int i = 0; i < NUM_PORTS; i++) begin
                                hop[i] <= dir_e'(3'(i));
                        end
                        change_order <= port_vec_t'($urandom);
                end
                repeat (RANDOM_CYCLES) begin
                        @(posedge clk);
                        for (int i = 0; i < NUM_PORTS; i++) begin
                                hop[i] <= random_hop();
                        end
                        change_order <= port_vec_t'($urandom);
                end
                repeat (2) @(posedge clk);
                $display("No errors");
                $finish;
        end

endmodule

// ==== verilog.f ====
design/router_pkg.sv
design/route_req_if.sv
design/rr_comparator.sv
design/rr_priority_ring.sv
design/grant_encoder.sv
design/rr_processor.sv
design/switch_allocator.sv
tests/tb_switch_allocator.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the switch allocator testbench with Verilator and runs it.
# The exit status of the simulation binary is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module tb_switch_allocator \
        -f verilog.f -Mdir obj_dir

./obj_dir/Vtb_switch_allocator
